// ==== hdl/rvv_lite_pkg.sv ====
package rvv_lite_pkg;

  // Front end
  localparam int issue_lane = 2;

  // Vector geometry with SEW 8 and LMUL 1
  localparam int vlen     = 64;
  localparam int sew      = 8;
  localparam int num_elem = vlen / sew;
  localparam int num_vreg = 32;

  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      vreg_idx_t;
  typedef logic [vlen-1:0] vreg_data_t;
  typedef logic [sew-1:0]  elem_t;

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_illegal
  } valu_op_e;

  // OP-V major opcode, OPIVV encoding
  localparam logic [6:0] opcode_op_v  = 7'b1010111;
  localparam logic [2:0] funct3_opivv = 3'b000;

  localparam logic [5:0] funct6_vadd = 6'b000000;
  localparam logic [5:0] funct6_vsub = 6'b000010;
  localparam logic [5:0] funct6_vand = 6'b001001;
  localparam logic [5:0] funct6_vor  = 6'b001010;
  localparam logic [5:0] funct6_vxor = 6'b001011;

  // Register r starts with byte j equal to r*8 + j, wrapping at 256
  function automatic vreg_data_t vrf_reset_value(input vreg_idx_t r);
    vreg_data_t val;
    for (int j = 0; j < num_elem; j++) begin
      val[j*sew +: sew] = elem_t'(int'(r) * num_elem + j);
    end
    return val;
  endfunction

endpackage

// ==== hdl/cmd_queue.sv ====
`timescale 1ns/1ps

module cmd_queue #(
  parameter int cq_depth = 8
) (
  input  logic                                              clk,
  input  logic                                              rst_n,

  input  logic                [rvv_lite_pkg::issue_lane-1:0] push_valid,
  input  rvv_lite_pkg::inst_t [rvv_lite_pkg::issue_lane-1:0] push_inst,
  output logic                [rvv_lite_pkg::issue_lane-1:0] push_ready,

  output logic                                              cq_valid,
  output rvv_lite_pkg::inst_t                               cq_inst,
  input  logic                                              cq_pop
);

  localparam int ptr_w = $clog2(cq_depth);
  localparam int cnt_w = ptr_w + 1;

  rvv_lite_pkg::inst_t mem [cq_depth];

  logic [ptr_w-1:0]                  wr_ptr;
  logic [ptr_w-1:0]                  rd_ptr;
  logic [cnt_w-1:0]                  count;
  logic [cnt_w-1:0]                  count_next;
  logic [cnt_w-1:0]                  free_next;
  logic [cnt_w-1:0]                  push_num;
  logic [rvv_lite_pkg::issue_lane-1:0] push_fire;

  assign push_fire = push_valid & push_ready;

  // Lanes fire as a contiguous group starting at lane 0
  always_comb begin
    push_num = '0;
    for (int l = 0; l < rvv_lite_pkg::issue_lane; l++) begin
      push_num = push_num + cnt_w'(push_fire[l]);
    end
  end

  assign count_next = count + push_num - cnt_w'(cq_pop);
  assign free_next  = cnt_w'(cq_depth) - count_next;

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + push_num[ptr_w-1:0];
      rd_ptr <= rd_ptr + ptr_w'(cq_pop);
      count  <= count_next;
    end
  end

  // Lane l may push when at least l+1 entries are free next cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      push_ready <= '0;
    end else begin
      for (int l = 0; l < rvv_lite_pkg::issue_lane; l++) begin
        push_ready[l] <= free_next > cnt_w'(l);
      end
    end
  end

  // Lane l lands l slots past the write pointer
  always_ff @(posedge clk) begin
    for (int l = 0; l < rvv_lite_pkg::issue_lane; l++) begin
      if (push_fire[l]) begin
        mem[wr_ptr + ptr_w'(l)] <= push_inst[l];
      end
    end
  end

  assign cq_valid = (count != '0);
  assign cq_inst  = mem[rd_ptr];

  // Younger lane never enters without the older one
  a_lane_order: assert property (
    @(posedge clk) disable iff (!rst_n)
    push_fire[1] |-> push_fire[0]
  ) else $error("cmd_queue: lane 1 pushed without lane 0");

  // Registered ready must never admit more than the free space
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    push_num <= cnt_w'(cq_depth) - count
  ) else $error("cmd_queue: push of %0d entries with %0d stored", push_num, count);

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    cq_pop |-> cq_valid
  ) else $error("cmd_queue: pop while empty");

endmodule

// ==== hdl/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      cq_valid,
  input  rvv_lite_pkg::inst_t       cq_inst,
  output logic                      cq_pop,

  output logic                      uop_valid,
  output rvv_lite_pkg::valu_op_e    uop_op,
  output rvv_lite_pkg::vreg_idx_t   uop_vd,
  output rvv_lite_pkg::vreg_idx_t   uop_vs1,
  output rvv_lite_pkg::vreg_idx_t   uop_vs2,
  input  logic                      uop_ready
);

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [5:0]             funct6;
  logic                   vm;
  rvv_lite_pkg::valu_op_e dec_op;

  // Instruction fields
  assign opcode = cq_inst[6:0];
  assign funct3 = cq_inst[14:12];
  assign vm     = cq_inst[25];
  assign funct6 = cq_inst[31:26];

  // Only unmasked OPIVV integer ops are supported
  always_comb begin
    dec_op = rvv_lite_pkg::op_illegal;
    if (opcode == rvv_lite_pkg::opcode_op_v &&
        funct3 == rvv_lite_pkg::funct3_opivv && vm) begin
      case (funct6)
        rvv_lite_pkg::funct6_vadd: dec_op = rvv_lite_pkg::op_add;
        rvv_lite_pkg::funct6_vsub: dec_op = rvv_lite_pkg::op_sub;
        rvv_lite_pkg::funct6_vand: dec_op = rvv_lite_pkg::op_and;
        rvv_lite_pkg::funct6_vor:  dec_op = rvv_lite_pkg::op_or;
        rvv_lite_pkg::funct6_vxor: dec_op = rvv_lite_pkg::op_xor;
        default:                   dec_op = rvv_lite_pkg::op_illegal;
      endcase
    end
  end

  // Refill in the same cycle the held uop leaves
  assign cq_pop = cq_valid && (!uop_valid || uop_ready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uop_valid <= 1'b0;
    end else if (cq_pop) begin
      uop_valid <= 1'b1;
    end else if (uop_ready) begin
      uop_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cq_pop) begin
      uop_op  <= dec_op;
      uop_vd  <= cq_inst[11:7];
      uop_vs1 <= cq_inst[19:15];
      uop_vs2 <= cq_inst[24:20];
    end
  end

  a_uop_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    uop_valid && !uop_ready |=>
      uop_valid && $stable(uop_op) && $stable(uop_vd) &&
      $stable(uop_vs1) && $stable(uop_vs2)
  ) else $error("inst_decode: uop changed while stalled");

endmodule

// ==== hdl/vec_exec.sv ====
`timescale 1ns/1ps

module vec_exec (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      uop_valid,
  input  rvv_lite_pkg::valu_op_e    uop_op,
  input  rvv_lite_pkg::vreg_idx_t   uop_vd,
  input  rvv_lite_pkg::vreg_idx_t   uop_vs1,
  input  rvv_lite_pkg::vreg_idx_t   uop_vs2,
  output logic                      uop_ready,

  output logic                      rt_valid,
  output rvv_lite_pkg::vreg_idx_t   rt_vd,
  output rvv_lite_pkg::vreg_data_t  rt_data,
  output logic                      rt_illegal,
  input  logic                      rt_ready
);

  rvv_lite_pkg::vreg_data_t vrf [rvv_lite_pkg::num_vreg];

  rvv_lite_pkg::vreg_data_t src1;
  rvv_lite_pkg::vreg_data_t src2;
  rvv_lite_pkg::vreg_data_t result;
  logic                     accept;
  logic                     is_illegal;
  logic                     wr_en;

  // One element, wrapping arithmetic, no carry out
  function automatic rvv_lite_pkg::elem_t elem_alu(
    input rvv_lite_pkg::valu_op_e op,
    input rvv_lite_pkg::elem_t    a,
    input rvv_lite_pkg::elem_t    b
  );
    case (op)
      rvv_lite_pkg::op_add: return a + b;
      rvv_lite_pkg::op_sub: return a - b;
      rvv_lite_pkg::op_and: return a & b;
      rvv_lite_pkg::op_or:  return a | b;
      rvv_lite_pkg::op_xor: return a ^ b;
      default:              return '0;
    endcase
  endfunction

  assign src1 = vrf[uop_vs1];
  assign src2 = vrf[uop_vs2];

  // vd = vs2 op vs1 per element
  always_comb begin
    result = '0;
    for (int e = 0; e < rvv_lite_pkg::num_elem; e++) begin
      result[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] =
        elem_alu(uop_op,
                 src2[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew],
                 src1[e*rvv_lite_pkg::sew +: rvv_lite_pkg::sew]);
    end
  end

  assign uop_ready  = !rt_valid || rt_ready;
  assign accept     = uop_valid && uop_ready;
  assign is_illegal = (uop_op == rvv_lite_pkg::op_illegal);
  assign wr_en      = accept && !is_illegal;

  // Register file, loaded with a known pattern on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < rvv_lite_pkg::num_vreg; r++) begin
        vrf[r] <= rvv_lite_pkg::vrf_reset_value(rvv_lite_pkg::vreg_idx_t'(r));
      end
    end else if (wr_en) begin
      vrf[uop_vd] <= result;
    end
  end

  // Retire slot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rt_valid <= 1'b0;
    end else if (accept) begin
      rt_valid <= 1'b1;
    end else if (rt_ready) begin
      rt_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rt_vd      <= uop_vd;
      rt_data    <= is_illegal ? '0 : result;
      rt_illegal <= is_illegal;
    end
  end

  a_rt_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    rt_valid && !rt_ready |=>
      rt_valid && $stable(rt_vd) && $stable(rt_data) && $stable(rt_illegal)
  ) else $error("vec_exec: retire output changed under back-pressure");

endmodule

// ==== hdl/rvv_lite_backend.sv ====
`timescale 1ns/1ps

module rvv_lite_backend #(
  parameter int cq_depth = 8
) (
  input  logic                                              clk,
  input  logic                                              rst_n,

  // Issue lanes, lane 0 is older
  input  logic                [rvv_lite_pkg::issue_lane-1:0] inst_valid,
  input  rvv_lite_pkg::inst_t [rvv_lite_pkg::issue_lane-1:0] inst,
  output logic                [rvv_lite_pkg::issue_lane-1:0] inst_ready,

  // Retire port
  output logic                                              rt_valid,
  output rvv_lite_pkg::vreg_idx_t                           rt_vd,
  output rvv_lite_pkg::vreg_data_t                          rt_data,
  output logic                                              rt_illegal,
  input  logic                                              rt_ready
);

  logic                    cq_valid;
  rvv_lite_pkg::inst_t     cq_inst;
  logic                    cq_pop;

  logic                    uop_valid;
  rvv_lite_pkg::valu_op_e  uop_op;
  rvv_lite_pkg::vreg_idx_t uop_vd;
  rvv_lite_pkg::vreg_idx_t uop_vs1;
  rvv_lite_pkg::vreg_idx_t uop_vs2;
  logic                    uop_ready;

  cmd_queue #(
    .cq_depth   (cq_depth)
  ) u_cmd_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (inst_valid),
    .push_inst  (inst),
    .push_ready (inst_ready),
    .cq_valid   (cq_valid),
    .cq_inst    (cq_inst),
    .cq_pop     (cq_pop)
  );

  inst_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .cq_valid   (cq_valid),
    .cq_inst    (cq_inst),
    .cq_pop     (cq_pop),
    .uop_valid  (uop_valid),
    .uop_op     (uop_op),
    .uop_vd     (uop_vd),
    .uop_vs1    (uop_vs1),
    .uop_vs2    (uop_vs2),
    .uop_ready  (uop_ready)
  );

  vec_exec u_exec (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop_valid  (uop_valid),
    .uop_op     (uop_op),
    .uop_vd     (uop_vd),
    .uop_vs1    (uop_vs1),
    .uop_vs2    (uop_vs2),
    .uop_ready  (uop_ready),
    .rt_valid   (rt_valid),
    .rt_vd      (rt_vd),
    .rt_data    (rt_data),
    .rt_illegal (rt_illegal),
    .rt_ready   (rt_ready)
  );

endmodule

// ==== test/tb_rvv_ref.svh ====
`ifndef TB_RVV_REF_SVH
`define TB_RVV_REF_SVH

// Expected register file, updated as instructions retire
rvv_lite_pkg::vreg_data_t ref_vrf [rvv_lite_pkg::num_vreg];

int unsigned lcg_state;

function automatic int unsigned lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state >> 8;
endfunction

function automatic void ref_reset();
  for (int r = 0; r < rvv_lite_pkg::num_vreg; r++) begin
    ref_vrf[r] = rvv_lite_pkg::vrf_reset_value(rvv_lite_pkg::vreg_idx_t'(r));
  end
endfunction

// Expected retire fields for one instruction word, vd = vs2 op vs1
function automatic void ref_execute(
  input  rvv_lite_pkg::inst_t      w,
  output rvv_lite_pkg::vreg_idx_t  vd,
  output rvv_lite_pkg::vreg_data_t data,
  output logic                     illegal
);
  rvv_lite_pkg::vreg_data_t a;
  rvv_lite_pkg::vreg_data_t b;
  rvv_lite_pkg::elem_t      x;
  rvv_lite_pkg::elem_t      y;
  logic [5:0]               f6;
  vd = w[11:7];
  a  = ref_vrf[w[24:20]];
  b  = ref_vrf[w[19:15]];
  f6 = w[31:26];
  illegal = (w[6:0] != rvv_lite_pkg::opcode_op_v) || (w[14:12] != rvv_lite_pkg::funct3_opivv) ||
            !w[25] ||
            !(f6 inside {rvv_lite_pkg::funct6_vadd, rvv_lite_pkg::funct6_vsub,
                         rvv_lite_pkg::funct6_vand, rvv_lite_pkg::funct6_vor,
                         rvv_lite_pkg::funct6_vxor});
  data = '0;
  if (!illegal) begin
    for (int j = 0; j < rvv_lite_pkg::num_elem; j++) begin
      x = a[j*rvv_lite_pkg::sew +: rvv_lite_pkg::sew];
      y = b[j*rvv_lite_pkg::sew +: rvv_lite_pkg::sew];
      case (f6)
        rvv_lite_pkg::funct6_vadd: data[j*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] = x + y;
        rvv_lite_pkg::funct6_vsub: data[j*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] = x - y;
        rvv_lite_pkg::funct6_vand: data[j*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] = x & y;
        rvv_lite_pkg::funct6_vor:  data[j*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] = x | y;
        default:                   data[j*rvv_lite_pkg::sew +: rvv_lite_pkg::sew] = x ^ y;
      endcase
    end
    ref_vrf[vd] = data;
  end
endfunction

`endif

// ==== test/tb_rvv_lite.sv ====
`timescale 1ns/1ps

module tb_rvv_lite;

  localparam int wait_limit = 2000;

  logic                                              clk;
  logic                                              rst_n;
  logic                [rvv_lite_pkg::issue_lane-1:0] inst_valid;
  rvv_lite_pkg::inst_t [rvv_lite_pkg::issue_lane-1:0] inst;
  logic                [rvv_lite_pkg::issue_lane-1:0] inst_ready;
  logic                                              rt_valid;
  rvv_lite_pkg::vreg_idx_t                           rt_vd;
  rvv_lite_pkg::vreg_data_t                          rt_data;
  logic                                              rt_illegal;
  logic                                              rt_ready;

  // Retire-side controls
  logic hold;
  logic gap_en;

  // Instructions sent and not yet retired, oldest first
  rvv_lite_pkg::inst_t sent_q [$];

  `include "tb_rvv_ref.svh"

  rvv_lite_backend #(
    .cq_depth   (8)
  ) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready),
    .rt_valid   (rt_valid),
    .rt_vd      (rt_vd),
    .rt_data    (rt_data),
    .rt_illegal (rt_illegal),
    .rt_ready   (rt_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Advance to the next falling edge and refresh rt_ready
  task automatic tick();
    @(negedge clk);
    rt_ready = !hold && (!gap_en || (lcg_next() % 4 != 0));
  endtask

  function automatic rvv_lite_pkg::inst_t make_opivv(
    input logic [5:0]              f6,
    input rvv_lite_pkg::vreg_idx_t vd,
    input rvv_lite_pkg::vreg_idx_t vs2,
    input rvv_lite_pkg::vreg_idx_t vs1
  );
    return {f6, 1'b1, vs2, vs1, rvv_lite_pkg::funct3_opivv, vd, rvv_lite_pkg::opcode_op_v};
  endfunction

  function automatic logic [5:0] funct6_of(input int k);
    case (k)
      0:       return rvv_lite_pkg::funct6_vadd;
      1:       return rvv_lite_pkg::funct6_vsub;
      2:       return rvv_lite_pkg::funct6_vand;
      3:       return rvv_lite_pkg::funct6_vor;
      default: return rvv_lite_pkg::funct6_vxor;
    endcase
  endfunction

  // Mostly legal ops, some masked or with an unknown funct6
  function automatic rvv_lite_pkg::inst_t rand_inst();
    int unsigned             sel;
    rvv_lite_pkg::vreg_idx_t vd;
    rvv_lite_pkg::vreg_idx_t vs1;
    rvv_lite_pkg::vreg_idx_t vs2;
    rvv_lite_pkg::inst_t     w;
    sel = lcg_next() % 12;
    vd  = rvv_lite_pkg::vreg_idx_t'(lcg_next());
    vs2 = rvv_lite_pkg::vreg_idx_t'(lcg_next());
    vs1 = rvv_lite_pkg::vreg_idx_t'(lcg_next());
    w   = make_opivv(funct6_of(int'(sel % 5)), vd, vs2, vs1);
    if (sel == 10) begin
      w[25] = 1'b0;
    end else if (sel == 11) begin
      w[31:26] = 6'b111000;
    end
    return w;
  endfunction

  // Push one or two instructions once the lanes can take them
  task automatic send(input int n, input rvv_lite_pkg::inst_t i0, input rvv_lite_pkg::inst_t i1);
    int waited;
    waited = 0;
    while (!inst_ready[n-1]) begin
      tick();
      waited++;
      if (waited > wait_limit) abort_run("Timeout: issue lanes never became ready");
    end
    inst[0]    = i0;
    inst[1]    = i1;
    inst_valid = (n == 2) ? 2'b11 : 2'b01;
    sent_q.push_back(i0);
    if (n == 2) sent_q.push_back(i1);
    tick();
    inst_valid = '0;
  endtask

  task automatic wait_retired();
    int waited;
    waited = 0;
    while (sent_q.size() != 0) begin
      tick();
      waited++;
      if (waited > wait_limit) abort_run("Timeout: retire port stopped before all retired");
    end
  endtask

  // Every retire transfer is checked against the oldest sent instruction
  always @(posedge clk) begin : compare_retire
    rvv_lite_pkg::inst_t      w;
    rvv_lite_pkg::vreg_idx_t  e_vd;
    rvv_lite_pkg::vreg_data_t e_data;
    logic                     e_ill;
    if (rst_n && rt_valid && rt_ready) begin
      if (sent_q.size() == 0) begin
        abort_run("Retire seen with no instruction outstanding");
      end else begin
        w = sent_q.pop_front();
        ref_execute(w, e_vd, e_data, e_ill);
        check("rt_vd", 64'(rt_vd), 64'(e_vd));
        check("rt_illegal", 64'(rt_illegal), 64'(e_ill));
        check("rt_data", rt_data, e_data);
      end
    end
  end

  initial begin
    rvv_lite_pkg::inst_t w0;
    rvv_lite_pkg::inst_t w1;
    int                  n;
    rst_n      = 1'b0;
    inst_valid = '0;
    inst       = '0;
    rt_ready   = 1'b1;
    hold       = 1'b0;
    gap_en     = 1'b0;
    lcg_state  = 32'd16064;
    ref_reset();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    tick();

    // Each op alone on untouched registers
    for (int k = 0; k < 5; k++) begin
      w0 = make_opivv(funct6_of(k), rvv_lite_pkg::vreg_idx_t'(k + 1),
                      rvv_lite_pkg::vreg_idx_t'(31 - k), rvv_lite_pkg::vreg_idx_t'(26 - k));
      send(1, w0, '0);
      wait_retired();
    end

    // Lane 1 reads what lane 0 writes
    send(2, make_opivv(rvv_lite_pkg::funct6_vadd, 5'd6, 5'd20, 5'd21),
            make_opivv(rvv_lite_pkg::funct6_vsub, 5'd7, 5'd6, 5'd8));
    send(2, make_opivv(rvv_lite_pkg::funct6_vxor, 5'd8, 5'd7, 5'd6),
            make_opivv(rvv_lite_pkg::funct6_vor, 5'd6, 5'd8, 5'd8));
    wait_retired();

    // Bad opcode, funct3, funct6 and vm, all aimed at v9
    w0 = make_opivv(rvv_lite_pkg::funct6_vadd, 5'd9, 5'd1, 5'd2);
    w0[6:0] = 7'b0110011;
    send(1, w0, '0);
    w0 = make_opivv(rvv_lite_pkg::funct6_vadd, 5'd9, 5'd1, 5'd2);
    w0[14:12] = 3'b011;
    send(1, w0, '0);
    w0 = make_opivv(6'b100101, 5'd9, 5'd1, 5'd2);
    w1 = make_opivv(rvv_lite_pkg::funct6_vand, 5'd9, 5'd1, 5'd2);
    w1[25] = 1'b0;
    send(2, w0, w1);
    send(1, make_opivv(rvv_lite_pkg::funct6_vadd, 5'd10, 5'd9, 5'd0), '0);
    wait_retired();

    // Retire port stalled while single instructions keep arriving
    hold = 1'b1;
    for (int k = 0; k < 16; k++) begin
      if (inst_ready[0]) begin
        w0 = make_opivv(funct6_of(k % 5), rvv_lite_pkg::vreg_idx_t'(k + 16),
                        rvv_lite_pkg::vreg_idx_t'(k), rvv_lite_pkg::vreg_idx_t'(k + 15));
        inst[0]    = w0;
        inst_valid = 2'b01;
        sent_q.push_back(w0);
      end
      tick();
      inst_valid = '0;
    end
    check("inst_ready", 64'(inst_ready), 64'(0));
    hold = 1'b0;
    wait_retired();

    // Random stream with gaps on rt_ready
    gap_en = 1'b1;
    for (int k = 0; k < 300; k++) begin
      n  = (lcg_next() % 3 == 0) ? 2 : 1;
      w0 = rand_inst();
      w1 = rand_inst();
      send(n, w0, w1);
      if (lcg_next() % 8 == 0) tick();
    end
    gap_en = 1'b0;
    wait_retired();

    repeat (4) tick();
    if (sent_q.size() != 0 || rt_valid) begin
      $display("Instructions left unretired at the end of the run");
      $display("TESTS FAILED");
      $fatal(1, "unretired instructions");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
+incdir+test
hdl/rvv_lite_pkg.sv
hdl/cmd_queue.sv
hdl/inst_decode.sv
hdl/vec_exec.sv
hdl/rvv_lite_backend.sv
test/tb_rvv_lite.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector back-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_rvv_lite \
  -f sources.f \
  --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
  echo "Run passed, log in $LOG"
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1
